// ==== Bender.yml ====
package:
  name: ccx_arbc

export_include_dirs:
  - hdl

sources:
  - hdl/ccx_arb_pkg.sv
  - hdl/ccx_dp_pkg.sv
  - hdl/ccx_arb_qtrack.sv
  - hdl/ccx_arb_prio.sv
  - hdl/ccx_arb_pick.sv
  - hdl/ccx_arbc.sv
  - target: test
    files:
      - dv/ccx_arbc_tb.sv

// ==== ccx_arbc.f ====
+incdir+hdl
hdl/ccx_arb_pkg.sv
hdl/ccx_dp_pkg.sv
hdl/ccx_arb_qtrack.sv
hdl/ccx_arb_prio.sv
hdl/ccx_arb_pick.sv
hdl/ccx_arbc.sv
dv/ccx_arbc_tb.sv

// ==== dv/ccx_arbc_tb.sv ====
`timescale 1ns/1ns
`include "ccx_consts.svh"

module ccx_arbc_tb;

   localparam int         MAX_RECS  = 64;      // Upper bound on file records
   localparam int         REC_WORDS = 7;       // Hex words per record
   localparam int         RST_WAIT  = 20;      // Cycles allowed for outputs to clear
   localparam logic [7:0] SECT_MARK = 8'hff;   // Random idle gap before next section
   localparam logic [7:0] END_MARK  = 8'hfe;

   logic                   rclk;
   logic                   rst_n;
   ccx_arb_pkg::src_req_t  req;
   logic                   stall;
   ccx_dp_pkg::dp_ctl_t    dp_ctl;
   ccx_dp_pkg::dest_stat_t dest;

   logic [7:0] tv [0:MAX_RECS*REC_WORDS-1];    // Flat vector memory
   logic [`CCX_NUM_SRC-1:0] tail_exp;          // Expected tail slot per source
   int         rec;
   int         wait_cnt;
   logic       done;

   ccx_arbc dut0 (
      .rclk   (rclk),
      .rst_n  (rst_n),
      .req    (req),
      .stall  (stall),
      .dp_ctl (dp_ctl),
      .dest   (dest)
   );

   //////////////////////////////
   // Clock
   //////////////////////////////

   initial rclk = 1'b0;
   always #4 rclk = ~rclk;                      // 8 ns period

   //////////////////////////////
   // Helpers
   //////////////////////////////

   task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Finished with errors");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "Run aborted");
   endtask

   // One file record, one clock cycle
   task automatic apply_record(input int base);
      logic [`CCX_NUM_SRC-1:0] strobe;
      strobe = tv[base][`CCX_NUM_SRC-1:0];
      @(posedge rclk);
      req.req  <= strobe;
      req.atom <= tv[base+1][`CCX_NUM_SRC-1:0];
      stall    <= tv[base+2][0];
      @(negedge rclk);                          // Outputs settled by mid cycle
      check("grant_a", dp_ctl.grant_a, tv[base+3]);
      check("qsel1_a", dp_ctl.qsel1_a, tv[base+4]);
      // Strobe loads the tail slot and flips the tail
      check("wr0_a", dp_ctl.wr0_a, strobe & ~tail_exp);
      check("wr1_a", dp_ctl.wr1_a, strobe & tail_exp);
      check("data_rdy_x", dest.data_rdy_x, tv[base+5]);
      check("atom_x", dest.atom_x, tv[base+6]);
      tail_exp = tail_exp ^ strobe;
   endtask

   // Quiet cycles between sections with queues drained
   task automatic idle_gap(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(posedge rclk);
         req   <= '0;
         stall <= 1'b0;
         @(negedge rclk);
         check("grant_a", dp_ctl.grant_a, 8'h00);
         check("data_rdy_x", dest.data_rdy_x, 8'h00);
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      rst_n    = 1'b0;
      req      = '0;
      stall    = 1'b0;
      done     = 1'b0;
      rec      = 0;
      wait_cnt = 0;
      tail_exp = '0;
      void'($urandom(32'hdc8c44bf));            // Seed once
      $readmemh("dv/ccx_arbc_tests.txt", tv);

      repeat (2) @(posedge rclk);               // Two reset edges
      rst_n <= 1'b1;

      // Outputs must come out of reset idle
      while ((dp_ctl !== '0 || dest !== '0) && wait_cnt < RST_WAIT) begin
         @(negedge rclk);
         wait_cnt++;
      end
      if (dp_ctl !== '0 || dest !== '0) begin
         fail_run("DUT outputs did not clear after reset");
      end

      // Walk the file until the end marker
      while (!done && rec < MAX_RECS && !$isunknown(tv[rec*REC_WORDS])) begin
         case (tv[rec*REC_WORDS])
            END_MARK:  done = 1'b1;
            SECT_MARK: idle_gap(1 + ($urandom % 4));
            default:   apply_record(rec*REC_WORDS);
         endcase
         rec++;
      end

      if (!done) begin
         fail_run("Test file is missing, truncated or has no end marker");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// ==== dv/ccx_arbc_tests.txt ====
// Columns: req atom stall | expected grant qsel1 data_rdy_x atom_x, hex, one cycle per line
// A req of ff inserts a random idle gap before the next section, fe ends the file
00 00 00 00 00 00 00 // all sources, rotating order then wrap
3f 00 00 00 00 00 00
01 00 00 01 00 00 00
00 00 00 02 00 01 00
00 00 00 04 00 01 00
00 00 00 08 00 01 00
00 00 00 10 00 01 00
00 00 00 20 00 01 00
00 00 00 01 01 01 00
00 00 00 00 00 01 00
ff 00 00 00 00 00 00 // back to back from one source, slots 0 then 1
01 00 00 00 00 00 00
01 00 00 01 00 00 00
00 00 00 01 01 01 00
00 00 00 00 00 01 00
ff 00 00 00 00 00 00 // atomic pair with others waiting
16 10 00 00 00 00 00
30 00 00 02 02 00 00
00 00 00 04 04 01 00
00 00 00 10 10 01 00
00 00 00 10 00 01 01
00 00 00 20 20 01 00
00 00 00 00 00 01 00
ff 00 00 00 00 00 00 // stall holds pointer and lock
0a 08 00 00 00 00 00
08 00 01 00 00 00 00
01 00 00 02 00 00 00
00 00 01 00 00 01 00
00 00 00 08 08 00 00
04 00 01 00 00 01 01
00 00 01 00 00 00 00
00 00 00 08 00 00 00
00 00 00 01 00 01 00
00 00 00 04 00 01 00
00 00 00 00 00 01 00
fe 00 00 00 00 00 00

// ==== hdl/ccx_arb_pick.sv ====
`timescale 1ns/1ns
`include "ccx_consts.svh"

// Grant select, atomic lock FSM and destination status
module ccx_arb_pick (
   input  logic                    rclk,
   input  logic                    rst_n,
   input  ccx_arb_pkg::occ_t       occ,        // Queue status
   input  logic [`CCX_NUM_SRC-1:0] mask,       // At or above pointer
   input  logic                    stall,      // Destination back-pressure
   output logic [`CCX_NUM_SRC-1:0] grant,      // a stage, one hot
   output logic                    lock_hold,  // Lock taken this cycle
   output ccx_dp_pkg::dest_stat_t  dest        // x stage
);

   ccx_arb_pkg::lock_state_e state_q;
   ccx_arb_pkg::lock_state_e state_nxt;
   logic [`CCX_NUM_SRC-1:0]  lock_src_q;       // Source owing second half
   logic [`CCX_NUM_SRC-1:0]  hi_req;
   logic [`CCX_NUM_SRC-1:0]  cand;
   logic [`CCX_NUM_SRC-1:0]  rr_pick;

   //////////////////////////////
   // Two-level priority find
   //////////////////////////////

   assign hi_req  = occ.nonempty & mask;
   assign cand    = (|hi_req) ? hi_req : occ.nonempty;   // Wrap if none above
   assign rr_pick = cand & (~cand + 1'b1);               // Lowest set bit

   //////////////////////////////
   // Lock FSM
   //////////////////////////////

   always_comb begin
      grant     = '0;
      state_nxt = state_q;
      case (state_q)
         ccx_arb_pkg::LOCK_IDLE: begin
            if (!stall) begin
               grant = rr_pick;
               if (|(rr_pick & occ.head_atom)) begin
                  state_nxt = ccx_arb_pkg::LOCK_ATOM;    // Partner next
               end
            end
         end
         ccx_arb_pkg::LOCK_ATOM: begin
            // Only the locked source, and only once its partner is queued
            if (!stall) begin
               grant = lock_src_q & occ.nonempty;
               if (|grant) begin
                  state_nxt = ccx_arb_pkg::LOCK_IDLE;
               end
            end
         end
         default: state_nxt = ccx_arb_pkg::LOCK_IDLE;
      endcase
   end

   // Freeze pointer on first half only
   assign lock_hold = (state_q == ccx_arb_pkg::LOCK_IDLE) &&
                      (state_nxt == ccx_arb_pkg::LOCK_ATOM);

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         state_q    <= ccx_arb_pkg::LOCK_IDLE;
         lock_src_q <= '0;
      end else begin
         state_q <= state_nxt;
         if (lock_hold) begin
            lock_src_q <= grant;                         // Remember owner
         end
      end
   end

   //////////////////////////////
   // Destination status, x stage
   //////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         dest <= '0;
      end else begin
         dest.data_rdy_x <= |grant;
         dest.atom_x     <= |(grant & occ.head_atom);    // Granted head atomic
      end
   end

endmodule

// ==== hdl/ccx_arb_pkg.sv ====
`include "ccx_consts.svh"

package ccx_arb_pkg;

   //////////////////////////////
   // Request side
   //////////////////////////////

   // One cycle of source strobes
   typedef struct packed {
      logic [`CCX_NUM_SRC-1:0] req;        // Packet strobe per source
      logic [`CCX_NUM_SRC-1:0] atom;       // Packet is first of atomic pair
   } src_req_t;

   // Pick FSM
   typedef enum logic {
      LOCK_IDLE = 1'b0,                    // Free round robin
      LOCK_ATOM = 1'b1                     // Second half of pair owed
   } lock_state_e;

   // Queue status seen by the picker
   typedef struct packed {
      logic [`CCX_NUM_SRC-1:0] nonempty;   // At least one valid slot
      logic [`CCX_NUM_SRC-1:0] head;       // Slot at the head
      logic [`CCX_NUM_SRC-1:0] head_atom;  // Head entry marked atomic
   } occ_t;

endpackage

// ==== hdl/ccx_arb_prio.sv ====
`timescale 1ns/1ns
`include "ccx_consts.svh"

// Rotating priority pointer
module ccx_arb_prio (
   input  logic                    rclk,
   input  logic                    rst_n,
   input  logic [`CCX_NUM_SRC-1:0] grant,      // One-hot winner
   input  logic                    lock_hold,  // First half of atomic pair
   output logic [`CCX_NUM_SRC-1:0] mask        // Sources at or above pointer
);

   localparam int PW = $clog2(`CCX_NUM_SRC);

   logic [PW-1:0] ptr_q;                       // Highest priority source
   logic [PW-1:0] win_idx;                     // Encoded winner
   logic [PW-1:0] ptr_nxt;

   //////////////////////////////
   // Pointer update
   //////////////////////////////

   // One-hot to index
   always_comb begin
      win_idx = '0;
      for (int i = 0; i < `CCX_NUM_SRC; i++) begin
         if (grant[i]) begin
            win_idx = PW'(i);
         end
      end
   end

   // Winner plus one, wrap at source count
   assign ptr_nxt = (win_idx == PW'(`CCX_NUM_SRC - 1)) ? '0 : win_idx + 1'b1;

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         ptr_q <= '0;
      end else if (|grant && !lock_hold) begin
         ptr_q <= ptr_nxt;                     // Held across atomic pair
      end
   end

   //////////////////////////////
   // Round-robin mask
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < `CCX_NUM_SRC; i++) begin
         mask[i] = (PW'(i) >= ptr_q);
      end
   end

endmodule

// ==== hdl/ccx_arb_qtrack.sv ====
`timescale 1ns/1ns
`include "ccx_consts.svh"

// Per-source two-entry queue bookkeeping
// Payload lives in the datapath; only valid/atomic/pointers kept here
module ccx_arb_qtrack (
   input  logic                    rclk,
   input  logic                    rst_n,
   input  ccx_arb_pkg::src_req_t   req,       // Strobes from sources
   input  logic [`CCX_NUM_SRC-1:0] grant,     // Pops, from picker
   output ccx_arb_pkg::occ_t       occ,       // Status to picker
   output ccx_dp_pkg::dp_ctl_t     slot_ctl   // Slot controls to datapath
);

   //////////////////////////////
   // Queue state
   //////////////////////////////

   logic [`CCX_NUM_SRC-1:0][`CCX_Q_DEPTH-1:0] vld_q;   // Slot holds a packet
   logic [`CCX_NUM_SRC-1:0][`CCX_Q_DEPTH-1:0] atm_q;   // Slot packet atomic
   logic [`CCX_NUM_SRC-1:0]                   head_q;  // Oldest slot
   logic [`CCX_NUM_SRC-1:0]                   tail_q;  // Next slot to load
   logic [`CCX_NUM_SRC-1:0]                   wr0;
   logic [`CCX_NUM_SRC-1:0]                   wr1;
   logic [`CCX_NUM_SRC-1:0]                   pop;

   // Write steers by tail
   assign wr0 = req.req & ~tail_q;
   assign wr1 = req.req & tail_q;
   assign pop = grant;                             // Grant always takes head

   // Control bits
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         vld_q  <= '0;
         head_q <= '0;
         tail_q <= '0;
      end else begin
         for (int i = 0; i < `CCX_NUM_SRC; i++) begin
            // Pop first so a same-cycle load into that slot wins
            if (pop[i]) begin
               vld_q[i][head_q[i]] <= 1'b0;
               head_q[i]           <= ~head_q[i];
            end
            if (wr0[i]) begin
               vld_q[i][`CCX_SLOT0] <= 1'b1;
            end
            if (wr1[i]) begin
               vld_q[i][`CCX_SLOT1] <= 1'b1;
            end
            if (req.req[i]) begin
               tail_q[i] <= ~tail_q[i];           // Toggle on every load
            end
         end
      end
   end

   // Atomic flag rides with the slot
   always_ff @(posedge rclk) begin
      for (int i = 0; i < `CCX_NUM_SRC; i++) begin
         if (wr0[i]) begin
            atm_q[i][`CCX_SLOT0] <= req.atom[i];
         end
         if (wr1[i]) begin
            atm_q[i][`CCX_SLOT1] <= req.atom[i];
         end
      end
   end

   //////////////////////////////
   // Status out
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < `CCX_NUM_SRC; i++) begin
         occ.nonempty[i]  = |vld_q[i];
         occ.head[i]      = head_q[i];
         // Only meaningful when head slot is valid
         occ.head_atom[i] = vld_q[i][head_q[i]] & atm_q[i][head_q[i]];
      end
   end

   // Datapath slot controls
   assign slot_ctl.grant_a = pop;                  // Queues popped this cycle
   assign slot_ctl.qsel1_a = grant & head_q;       // Read head slot of winner
   assign slot_ctl.wr0_a   = wr0;
   assign slot_ctl.wr1_a   = wr1;

endmodule

// ==== hdl/ccx_arbc.sv ====
`timescale 1ns/1ns
`include "ccx_consts.svh"

// Crossbar arbiter for one destination
module ccx_arbc (
   input  logic                   rclk,
   input  logic                   rst_n,
   input  ccx_arb_pkg::src_req_t  req,      // Source strobes
   input  logic                   stall,    // Destination full
   output ccx_dp_pkg::dp_ctl_t    dp_ctl,   // a stage datapath controls
   output ccx_dp_pkg::dest_stat_t dest      // x stage status
);

   ccx_arb_pkg::occ_t       occ;
   ccx_dp_pkg::dp_ctl_t     slot_ctl;
   logic [`CCX_NUM_SRC-1:0] mask;
   logic [`CCX_NUM_SRC-1:0] grant;
   logic                    lock_hold;

   ccx_arb_qtrack u_qtrack (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .req       (req),
      .grant     (grant),
      .occ       (occ),
      .slot_ctl  (slot_ctl)
   );

   ccx_arb_prio u_prio (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .grant     (grant),
      .lock_hold (lock_hold),
      .mask      (mask)
   );

   ccx_arb_pick u_pick (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .occ       (occ),
      .mask      (mask),
      .stall     (stall),
      .grant     (grant),
      .lock_hold (lock_hold),
      .dest      (dest)
   );

   // Grant from picker, slot fields from tracker
   assign dp_ctl.grant_a = grant;
   assign dp_ctl.qsel1_a = slot_ctl.qsel1_a;
   assign dp_ctl.wr0_a   = slot_ctl.wr0_a;
   assign dp_ctl.wr1_a   = slot_ctl.wr1_a;

endmodule

// ==== hdl/ccx_consts.svh ====
`ifndef CCX_CONSTS_SVH
`define CCX_CONSTS_SVH

//////////////////////////////
// Arbiter sizing
//////////////////////////////

// Sources feeding one destination
`define CCX_NUM_SRC 6

// Entries per source request queue
// Head and tail pointers are one bit, so keep this at 2
`define CCX_Q_DEPTH 2

// Slot indices inside a source queue
`define CCX_SLOT0 1'b0
`define CCX_SLOT1 1'b1

`endif

// ==== hdl/ccx_dp_pkg.sv ====
`include "ccx_consts.svh"

package ccx_dp_pkg;

   //////////////////////////////
   // Datapath and destination
   //////////////////////////////

   // Controls to the payload queues and output mux, one bit per source
   typedef struct packed {
      logic [`CCX_NUM_SRC-1:0] grant_a;    // Granted source, one hot
      logic [`CCX_NUM_SRC-1:0] qsel1_a;    // Read slot 1, with grant
      logic [`CCX_NUM_SRC-1:0] wr0_a;      // Load slot 0
      logic [`CCX_NUM_SRC-1:0] wr1_a;      // Load slot 1
   } dp_ctl_t;

   // Status to the destination, x stage
   typedef struct packed {
      logic data_rdy_x;                    // Packet on the bus
      logic atom_x;                        // Packet opens an atomic pair
   } dest_stat_t;

endpackage
